// File: common/pool_defines.svh
// sizes are fixed at build time; stride 2 and four lanes are the only supported setup
`ifndef POOL_DEFINES_SVH
`define POOL_DEFINES_SVH

// ======================================================================
// tile geometry
// ======================================================================

// side of the square partial-sum tile
`define POOL_TILE_LEN 8
// pooling window side, also the step between windows
`define POOL_STRIDE 2
`define POOL_NUM_LANES 4
// windows in one pass, (TILE_LEN / STRIDE) squared
`define POOL_NUM_WIN 16

// ======================================================================
// data and port widths
// ======================================================================

`define POOL_PSUM_WIDTH 16
`define POOL_DATA_WIDTH 8
`define POOL_PORT_WIDTH 32
// partial-sum read address, covers TILE_LEN * TILE_LEN entries
`define POOL_PSUM_AW 6
`define POOL_OFM_AW 10

`endif

// File: common/pool_pkg.sv
// lane vectors hold lane 0 in the lowest slice; widths come from the defines header
`include "pool_defines.svh"

package pool_pkg;

    // one partial sum per lane, as read from the partial-sum buffer
    typedef logic [`POOL_NUM_LANES-1:0][`POOL_PSUM_WIDTH-1:0] psum_vec_t;

    // one pooled byte per lane
    typedef logic [`POOL_NUM_LANES-1:0][`POOL_DATA_WIDTH-1:0] lane_vec_t;

    // nonzero marker per lane
    typedef logic [`POOL_NUM_LANES-1:0] lane_flags_t;

endpackage

// File: design/word_packer.sv
// IN_WIDTH must divide the port width; word_dat shows partial contents outside the strobe cycle
`timescale 1ns/1ns
`include "pool_defines.svh"

module word_packer #(
    parameter int IN_WIDTH = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clear,
    input  logic                        piece_wr,
    input  logic [IN_WIDTH-1:0]         piece,
    output logic                        word_wr,
    output logic [`POOL_OFM_AW-1:0]     word_addr,
    output logic [`POOL_PORT_WIDTH-1:0] word_dat
);

    localparam int NUM_PIECES = `POOL_PORT_WIDTH / IN_WIDTH;
    localparam int FW = $clog2(NUM_PIECES);
    localparam logic [FW-1:0] FILL_LAST = FW'(NUM_PIECES - 1);

    logic [FW-1:0] fill;

    // new pieces enter at the top, so the first one ends up in the low bits
    always_ff @(posedge clk) begin
        if (piece_wr) begin
            word_dat <= {piece, word_dat[`POOL_PORT_WIDTH-1:IN_WIDTH]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill    <= '0;
            word_wr <= 1'b0;
        end else begin
            word_wr <= piece_wr && (fill == FILL_LAST);
            if (piece_wr) begin
                fill <= (fill == FILL_LAST) ? '0 : fill + 1'b1;
            end
        end
    end

    // address moves on after the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_addr <= '0;
        end else if (clear) begin
            word_addr <= '0;
        end else if (word_wr) begin
            word_addr <= word_addr + 1'b1;
        end
    end

endmodule

// File: pool/pool_window_ctrl.sv
// start is ignored while busy; the partial-sum buffer must return data one cycle after a read
`timescale 1ns/1ns
`include "pool_defines.svh"

module pool_window_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     scan_done,
    output logic                     busy,
    output logic                     psum_rd_en,
    output logic [`POOL_PSUM_AW-1:0] psum_rd_addr,
    output logic                     rd_sample,
    output logic                     win_clear,
    output logic                     delta_rd,
    output logic                     delta_wr,
    output logic                     scan_start
);

    localparam int XW = $clog2(`POOL_STRIDE);
    localparam int CW = $clog2(`POOL_TILE_LEN);
    localparam int AW = `POOL_PSUM_AW;

    localparam logic [XW-1:0] XY_LAST  = XW'(`POOL_STRIDE - 1);
    localparam logic [CW-1:0] COL_STEP = CW'(`POOL_STRIDE);
    localparam logic [CW-1:0] COL_LAST = CW'(`POOL_TILE_LEN - `POOL_STRIDE);
    localparam logic [AW-1:0] ROW_STEP = AW'(`POOL_TILE_LEN * `POOL_STRIDE);
    localparam logic [AW-1:0] ROW_LAST = AW'(`POOL_TILE_LEN * (`POOL_TILE_LEN - `POOL_STRIDE));

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_CLEAR = 3'd1;
    localparam logic [2:0] ST_READ  = 3'd2;
    localparam logic [2:0] ST_DELTA = 3'd3;
    localparam logic [2:0] ST_SCAN  = 3'd4;

    logic [2:0]    state_q;
    logic [2:0]    state_d;
    logic [XW-1:0] cnt_x;
    logic [XW-1:0] cnt_y;
    logic [CW-1:0] col_base;
    logic [AW-1:0] row_base;
    logic          delta_ph;
    logic          read_last;
    logic          win_last;

    assign read_last = (cnt_x == XY_LAST) && (cnt_y == XY_LAST);
    assign win_last  = (col_base == COL_LAST) && (row_base == ROW_LAST);

    // ======================================================================
    // window sequencing: clear, 4 reads, 2 delta cycles, 4 scan cycles
    // ======================================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start) begin
                    state_d = ST_CLEAR;
                end
            end
            ST_CLEAR: state_d = ST_READ;
            ST_READ: begin
                if (read_last) begin
                    state_d = ST_DELTA;
                end
            end
            ST_DELTA: begin
                if (delta_ph) begin
                    state_d = ST_SCAN;
                end
            end
            ST_SCAN: begin
                if (scan_done) begin
                    state_d = win_last ? ST_IDLE : ST_CLEAR;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // position inside the window, x runs fastest
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_x <= '0;
            cnt_y <= '0;
        end else if (state_q == ST_READ) begin
            if (cnt_x == XY_LAST) begin
                cnt_x <= '0;
                cnt_y <= (cnt_y == XY_LAST) ? '0 : cnt_y + 1'b1;
            end else begin
                cnt_x <= cnt_x + 1'b1;
            end
        end
    end

    // window origin across the tile, raster order
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_base <= '0;
            row_base <= '0;
        end else if (state_q == ST_IDLE) begin
            col_base <= '0;
            row_base <= '0;
        end else if (state_q == ST_SCAN && scan_done) begin
            if (col_base == COL_LAST) begin
                col_base <= '0;
                row_base <= row_base + ROW_STEP;
            end else begin
                col_base <= col_base + COL_STEP;
            end
        end
    end

    // first or second delta cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            delta_ph <= 1'b0;
        end else if (state_q == ST_DELTA) begin
            delta_ph <= ~delta_ph;
        end
    end

    // read data valid one cycle late; scan begins right after the difference is stored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_sample  <= 1'b0;
            scan_start <= 1'b0;
        end else begin
            rd_sample  <= psum_rd_en;
            scan_start <= (state_q == ST_DELTA) && delta_ph;
        end
    end

    assign busy         = (state_q != ST_IDLE);
    assign win_clear    = (state_q == ST_CLEAR);
    assign psum_rd_en   = (state_q == ST_READ);
    assign delta_rd     = (state_q == ST_DELTA) && !delta_ph;
    assign delta_wr     = (state_q == ST_DELTA) && delta_ph;
    assign psum_rd_addr = row_base + AW'(col_base) + AW'(cnt_x)
                        + AW'(cnt_y) * AW'(`POOL_TILE_LEN);

endmodule

// File: pool/pool_lane_max.sv
// scale must be nonzero; quantized values keep only 7 bits, so the pooled byte is never negative
`timescale 1ns/1ns
`include "pool_defines.svh"

module pool_lane_max import pool_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         win_clear,
    input  logic                         rd_sample,
    input  psum_vec_t                    psum_dat,
    input  logic [`POOL_DATA_WIDTH-1:0]  scale,
    input  logic [`POOL_DATA_WIDTH-2:0]  bias,
    output lane_vec_t                    pooled
);

    localparam int QW = `POOL_DATA_WIDTH - 1;

    logic [`POOL_PSUM_WIDTH-1:0] relu [`POOL_NUM_LANES];
    lane_vec_t                   quant;

    // ======================================================================
    // relu and quantization per lane
    // ======================================================================

    always_comb begin
        for (int i = 0; i < `POOL_NUM_LANES; i++) begin
            // sign bit set means negative
            relu[i]  = psum_dat[i][`POOL_PSUM_WIDTH-1] ? '0 : psum_dat[i];
            quant[i] = {1'b0, QW'(relu[i] / scale + bias)};
        end
    end

    // running max over the four samples of the window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pooled <= '0;
        end else if (win_clear) begin
            pooled <= '0;
        end else if (rd_sample) begin
            for (int i = 0; i < `POOL_NUM_LANES; i++) begin
                if (quant[i] > pooled[i]) begin
                    pooled[i] <= quant[i];
                end
            end
        end
    end

endmodule

// File: pool/pool_delta.sv
// delta memory has no reset, so the first pass after power-up must run with delta_en low
`timescale 1ns/1ns
`include "pool_defines.svh"

module pool_delta import pool_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,
    input  logic      delta_en,
    input  logic      delta_rd,
    input  logic      delta_wr,
    input  lane_vec_t pooled,
    output lane_vec_t result
);

    localparam int WW = $clog2(`POOL_NUM_WIN);

    // pooled bytes of the previous pass, one entry per window
    lane_vec_t     mem [`POOL_NUM_WIN];
    lane_vec_t     stored;
    logic [WW-1:0] win_idx;
    logic          delta_on;

    // ======================================================================
    // window index and per-pass mode
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_idx  <= '0;
            delta_on <= 1'b0;
        end else if (start) begin
            win_idx  <= '0;
            delta_on <= delta_en;
        end else if (delta_wr) begin
            win_idx <= win_idx + 1'b1;
        end
    end

    // ======================================================================
    // memory access and difference
    // ======================================================================

    // first delta cycle fetches the old entry
    always_ff @(posedge clk) begin
        if (delta_rd) begin
            stored <= mem[win_idx];
        end
    end

    // second delta cycle: 8-bit two's complement difference, then overwrite
    always_ff @(posedge clk) begin
        if (delta_wr) begin
            mem[win_idx] <= pooled;
            for (int i = 0; i < `POOL_NUM_LANES; i++) begin
                result[i] <= pooled[i] - (delta_on ? stored[i] : '0);
            end
        end
    end

endmodule

// File: pool/sparse_encoder.sv
// flags of a window go out with its first scan cycle; partial words stay held, nothing flushes
`timescale 1ns/1ns
`include "pool_defines.svh"

module sparse_encoder import pool_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ofm_clear,
    input  logic                        scan_start,
    input  lane_vec_t                   result,
    output logic                        scan_done,
    output logic                        ofm_wr,
    output logic [`POOL_OFM_AW-1:0]     ofm_addr,
    output logic [`POOL_PORT_WIDTH-1:0] ofm_dat,
    output logic                        flg_wr,
    output logic [`POOL_OFM_AW-1:0]     flg_addr,
    output logic [`POOL_PORT_WIDTH-1:0] flg_dat
);

    localparam int LW = $clog2(`POOL_NUM_LANES);
    localparam logic [LW-1:0] LANE_LAST = LW'(`POOL_NUM_LANES - 1);

    lane_flags_t   flags;
    logic [LW-1:0] lane_idx;
    logic          scan_run;
    logic          scan_act;
    logic          byte_wr;

    always_comb begin
        for (int i = 0; i < `POOL_NUM_LANES; i++) begin
            flags[i] = |result[i];
        end
    end

    // ======================================================================
    // lane walk, one lane per cycle starting with scan_start
    // ======================================================================

    assign scan_act  = scan_start | scan_run;
    assign scan_done = scan_act && (lane_idx == LANE_LAST);
    // zero bytes are dropped
    assign byte_wr   = scan_act && flags[lane_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_run <= 1'b0;
            lane_idx <= '0;
        end else if (scan_done) begin
            scan_run <= 1'b0;
            lane_idx <= '0;
        end else if (scan_act) begin
            scan_run <= 1'b1;
            lane_idx <= lane_idx + 1'b1;
        end
    end

    word_packer #(
        .IN_WIDTH (`POOL_DATA_WIDTH)
    ) byte_packer (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (ofm_clear),
        .piece_wr  (byte_wr),
        .piece     (result[lane_idx]),
        .word_wr   (ofm_wr),
        .word_addr (ofm_addr),
        .word_dat  (ofm_dat)
    );

    word_packer #(
        .IN_WIDTH (`POOL_NUM_LANES)
    ) flag_packer (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (ofm_clear),
        .piece_wr  (scan_start),
        .piece     (flags),
        .word_wr   (flg_wr),
        .word_addr (flg_addr),
        .word_dat  (flg_dat)
    );

endmodule

// File: design/pool_top.sv
// no back-pressure: every ofm and flag write strobe must be taken in its cycle
`timescale 1ns/1ns
`include "pool_defines.svh"

module pool_top import pool_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        delta_en,
    input  logic [`POOL_DATA_WIDTH-1:0] scale,
    input  logic [`POOL_DATA_WIDTH-2:0] bias,
    input  logic                        ofm_clear,
    input  psum_vec_t                   psum_dat,
    output logic                        psum_rd_en,
    output logic [`POOL_PSUM_AW-1:0]    psum_rd_addr,
    output logic                        ofm_wr,
    output logic [`POOL_OFM_AW-1:0]     ofm_addr,
    output logic [`POOL_PORT_WIDTH-1:0] ofm_dat,
    output logic                        flg_wr,
    output logic [`POOL_OFM_AW-1:0]     flg_addr,
    output logic [`POOL_PORT_WIDTH-1:0] flg_dat,
    output logic                        busy
);

    logic      rd_sample;
    logic      win_clear;
    logic      delta_rd;
    logic      delta_wr;
    logic      scan_start;
    logic      scan_done;
    lane_vec_t pooled;
    lane_vec_t result;

    pool_window_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .scan_done    (scan_done),
        .busy         (busy),
        .psum_rd_en   (psum_rd_en),
        .psum_rd_addr (psum_rd_addr),
        .rd_sample    (rd_sample),
        .win_clear    (win_clear),
        .delta_rd     (delta_rd),
        .delta_wr     (delta_wr),
        .scan_start   (scan_start)
    );

    pool_lane_max u_lane_max (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_clear (win_clear),
        .rd_sample (rd_sample),
        .psum_dat  (psum_dat),
        .scale     (scale),
        .bias      (bias),
        .pooled    (pooled)
    );

    pool_delta u_delta (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .delta_en (delta_en),
        .delta_rd (delta_rd),
        .delta_wr (delta_wr),
        .pooled   (pooled),
        .result   (result)
    );

    sparse_encoder u_sparse (
        .clk        (clk),
        .rst_n      (rst_n),
        .ofm_clear  (ofm_clear),
        .scan_start (scan_start),
        .result     (result),
        .scan_done  (scan_done),
        .ofm_wr     (ofm_wr),
        .ofm_addr   (ofm_addr),
        .ofm_dat    (ofm_dat),
        .flg_wr     (flg_wr),
        .flg_addr   (flg_addr),
        .flg_dat    (flg_dat)
    );

endmodule

// File: bench/pool_tb.sv
// partial-sum buffer model answers one cycle after psum_rd_en; the first pass runs without delta
`timescale 1ns/1ns
`include "pool_defines.svh"

module pool_tb import pool_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 3000;
    localparam int PASS_CYCLES    = 176;
    localparam int WIN_PER_ROW    = `POOL_TILE_LEN / `POOL_STRIDE;
    localparam int TILE_WORDS     = `POOL_TILE_LEN * `POOL_TILE_LEN;
    localparam int WIN_READS      = `POOL_STRIDE * `POOL_STRIDE;

    logic                        clk;
    logic                        rst_n;
    logic                        start;
    logic                        delta_en;
    logic [`POOL_DATA_WIDTH-1:0] scale;
    logic [`POOL_DATA_WIDTH-2:0] bias;
    logic                        ofm_clear;
    psum_vec_t                   psum_dat = '0;
    logic                        psum_rd_en;
    logic [`POOL_PSUM_AW-1:0]    psum_rd_addr;
    logic                        ofm_wr;
    logic [`POOL_OFM_AW-1:0]     ofm_addr;
    logic [`POOL_PORT_WIDTH-1:0] ofm_dat;
    logic                        flg_wr;
    logic [`POOL_OFM_AW-1:0]     flg_addr;
    logic [`POOL_PORT_WIDTH-1:0] flg_dat;
    logic                        busy;

    // tile contents and the pooled bytes of the last pass
    psum_vec_t                psum_mem [TILE_WORDS];
    lane_vec_t                prev_pooled [`POOL_NUM_WIN];
    logic                     rd_pend = 1'b0;
    logic [`POOL_PSUM_AW-1:0] rd_addr_q;

    // write records hold the address above the data word
    logic [41:0] exp_ofm [$];
    logic [41:0] exp_flg [$];
    logic [41:0] got_ofm [$];
    logic [41:0] got_flg [$];
    logic [7:0]  byte_pend [$];
    logic [3:0]  flag_pend [$];
    int          ofm_addr_m;
    int          flg_addr_m;
    int          pass_ofm_base;
    int          pass_flg_base;
    int          busy_total = 0;
    int          rd_cnt = 0;
    int          cycle_cnt = 0;
    int          err_cnt = 0;
    int          chk_cnt = 0;

    pool_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .delta_en     (delta_en),
        .scale        (scale),
        .bias         (bias),
        .ofm_clear    (ofm_clear),
        .psum_dat     (psum_dat),
        .psum_rd_en   (psum_rd_en),
        .psum_rd_addr (psum_rd_addr),
        .ofm_wr       (ofm_wr),
        .ofm_addr     (ofm_addr),
        .ofm_dat      (ofm_dat),
        .flg_wr       (flg_wr),
        .flg_addr     (flg_addr),
        .flg_dat      (flg_dat),
        .busy         (busy)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ======================================================================
    // partial-sum buffer, monitor and timeout
    // ======================================================================

    always @(negedge clk) begin
        rd_pend   <= psum_rd_en;
        rd_addr_q <= psum_rd_addr;
    end

    // filler outside the valid cycle exposes a wrong sampling point
    always @(posedge clk) begin
        #2;
        psum_dat <= rd_pend ? psum_mem[rd_addr_q] : {`POOL_NUM_LANES{16'h5a5a}};
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (psum_rd_en) begin
                check_value("psum_rd_addr", 32'(psum_rd_addr), 32'(read_addr(rd_cnt)));
                rd_cnt++;
            end
            if (ofm_wr) begin
                got_ofm.push_back({ofm_addr, ofm_dat});
            end
            if (flg_wr) begin
                got_flg.push_back({flg_addr, flg_dat});
            end
            if (busy) begin
                busy_total++;
            end
        end
    end

    always @(negedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %s: %s", name, (err_cnt == errs_before) ? "ok" : "failed");
    endtask

    // ======================================================================
    // reference model
    // ======================================================================

    // origin of window w, windows in raster order
    function automatic int window_base(input int w);
        return (w / WIN_PER_ROW) * `POOL_TILE_LEN * `POOL_STRIDE
             + (w % WIN_PER_ROW) * `POOL_STRIDE;
    endfunction

    // address of read n within a pass, x runs fastest inside the window
    function automatic int read_addr(input int n);
        int k;
        k = n % WIN_READS;
        return window_base(n / WIN_READS) + k % `POOL_STRIDE
             + `POOL_TILE_LEN * (k / `POOL_STRIDE);
    endfunction

    function automatic logic [7:0] quantize(input logic [15:0] p, input logic [7:0] sc,
                                            input logic [6:0] bi);
        int q;
        if (p[15]) begin
            return 8'd0;
        end
        q = (int'(p) / int'(sc) + int'(bi)) % 128;
        return 8'(q);
    endfunction

    // first piece lands in the low byte
    task automatic push_byte(input logic [7:0] b);
        byte_pend.push_back(b);
        if (byte_pend.size() == 4) begin
            exp_ofm.push_back({10'(ofm_addr_m), byte_pend[3], byte_pend[2],
                               byte_pend[1], byte_pend[0]});
            ofm_addr_m++;
            byte_pend.delete();
        end
    endtask

    task automatic push_flag(input logic [3:0] f);
        logic [31:0] wd;
        flag_pend.push_back(f);
        if (flag_pend.size() == 8) begin
            wd = '0;
            for (int i = 0; i < 8; i++) begin
                wd[i*4 +: 4] = flag_pend[i];
            end
            exp_flg.push_back({10'(flg_addr_m), wd});
            flg_addr_m++;
            flag_pend.delete();
        end
    endtask

    task automatic model_pass(input logic use_delta, input logic [7:0] sc,
                              input logic [6:0] bi);
        int          base;
        logic [7:0]  q;
        logic [7:0]  mx;
        logic [7:0]  res;
        logic [3:0]  flags;
        lane_vec_t   bytes;
        for (int w = 0; w < `POOL_NUM_WIN; w++) begin
            base = window_base(w);
            for (int ln = 0; ln < `POOL_NUM_LANES; ln++) begin
                mx = 8'd0;
                for (int y = 0; y < `POOL_STRIDE; y++) begin
                    for (int x = 0; x < `POOL_STRIDE; x++) begin
                        q = quantize(psum_mem[base + x + `POOL_TILE_LEN * y][ln], sc, bi);
                        if (q > mx) begin
                            mx = q;
                        end
                    end
                end
                res = use_delta ? mx - prev_pooled[w][ln] : mx;
                prev_pooled[w][ln] = mx;
                bytes[ln] = res;
                flags[ln] = (res != 8'd0);
            end
            push_flag(flags);
            for (int ln = 0; ln < `POOL_NUM_LANES; ln++) begin
                if (flags[ln]) begin
                    push_byte(bytes[ln]);
                end
            end
        end
    endtask

    // ======================================================================
    // pass driver
    // ======================================================================

    task automatic fill_tile(input logic neg_odd);
        for (int a = 0; a < TILE_WORDS; a++) begin
            for (int ln = 0; ln < `POOL_NUM_LANES; ln++) begin
                psum_mem[a][ln] = 16'($urandom() & 32'h7fff);
                if (neg_odd && ln % 2 == 1) begin
                    psum_mem[a][ln][15] = 1'b1;
                end
            end
        end
    endtask

    task automatic run_pass(input logic use_delta, input logic [7:0] sc,
                            input logic [6:0] bi);
        int busy_base;
        int n_ofm;
        int n_flg;
        exp_ofm.delete();
        exp_flg.delete();
        model_pass(use_delta, sc, bi);
        pass_ofm_base = got_ofm.size();
        pass_flg_base = got_flg.size();
        @(posedge clk);
        #2;
        scale     = sc;
        bias      = bi;
        delta_en  = use_delta;
        start     = 1'b1;
        busy_base = busy_total;
        rd_cnt    = 0;
        @(posedge clk);
        #2;
        start = 1'b0;
        check_value("busy", 32'(busy), 32'd1);
        while (busy) begin
            @(negedge clk);
        end
        // last byte word strobes one cycle after busy falls
        repeat (2) @(negedge clk);
        n_ofm = got_ofm.size() - pass_ofm_base;
        n_flg = got_flg.size() - pass_flg_base;
        check_value("busy cycles", 32'(busy_total - busy_base), 32'(PASS_CYCLES));
        check_value("psum_rd_en count", 32'(rd_cnt), 32'(`POOL_NUM_WIN * WIN_READS));
        check_value("ofm_wr count", 32'(n_ofm), 32'(exp_ofm.size()));
        check_value("flg_wr count", 32'(n_flg), 32'(exp_flg.size()));
        for (int i = 0; i < n_ofm && i < exp_ofm.size(); i++) begin
            check_value("ofm_addr", 32'(got_ofm[pass_ofm_base + i][41:32]),
                        32'(exp_ofm[i][41:32]));
            check_value("ofm_dat", got_ofm[pass_ofm_base + i][31:0], exp_ofm[i][31:0]);
        end
        for (int i = 0; i < n_flg && i < exp_flg.size(); i++) begin
            check_value("flg_addr", 32'(got_flg[pass_flg_base + i][41:32]),
                        32'(exp_flg[i][41:32]));
            check_value("flg_dat", got_flg[pass_flg_base + i][31:0], exp_flg[i][31:0]);
        end
    endtask

    // ======================================================================
    // directed tests
    // ======================================================================

    task automatic test_reset_state();
        int errs;
        errs = err_cnt;
        @(negedge clk);
        check_value("busy", 32'(busy), 32'd0);
        check_value("psum_rd_en", 32'(psum_rd_en), 32'd0);
        check_value("ofm_wr", 32'(ofm_wr), 32'd0);
        check_value("flg_wr", 32'(flg_wr), 32'd0);
        check_value("ofm_addr", 32'(ofm_addr), 32'd0);
        check_value("flg_addr", 32'(flg_addr), 32'd0);
        report_test("reset state", errs);
    endtask

    task automatic test_pool_pass();
        int errs;
        errs = err_cnt;
        fill_tile(1'b0);
        run_pass(1'b0, 8'd37, 7'd5);
        report_test("pooling pass", errs);
    endtask

    task automatic test_relu_suppress();
        int errs;
        errs = err_cnt;
        fill_tile(1'b1);
        run_pass(1'b0, 8'd64, 7'd0);
        // lanes 1 and 3 are negative throughout
        for (int i = pass_flg_base; i < got_flg.size(); i++) begin
            check_value("flg_dat lanes 1 and 3", got_flg[i][31:0] & 32'haaaa_aaaa, 32'd0);
        end
        report_test("relu suppression", errs);
    endtask

    task automatic test_delta_repeat();
        int errs;
        errs = err_cnt;
        run_pass(1'b1, 8'd64, 7'd0);
        check_value("ofm_wr count", 32'(got_ofm.size() - pass_ofm_base), 32'd0);
        for (int i = pass_flg_base; i < got_flg.size(); i++) begin
            check_value("flg_dat", got_flg[i][31:0], 32'd0);
        end
        report_test("delta repeat", errs);
    endtask

    task automatic test_clear_delta();
        int errs;
        errs = err_cnt;
        @(posedge clk);
        #2;
        ofm_clear = 1'b1;
        @(posedge clk);
        #2;
        ofm_clear  = 1'b0;
        ofm_addr_m = 0;
        flg_addr_m = 0;
        @(negedge clk);
        check_value("ofm_addr", 32'(ofm_addr), 32'd0);
        check_value("flg_addr", 32'(flg_addr), 32'd0);
        // every third entry changes in all lanes
        for (int a = 0; a < TILE_WORDS; a += 3) begin
            for (int ln = 0; ln < `POOL_NUM_LANES; ln++) begin
                psum_mem[a][ln] = 16'($urandom() & 32'h7fff);
            end
        end
        run_pass(1'b1, 8'd64, 7'd0);
        report_test("clear and delta", errs);
    endtask

    initial begin
        void'($urandom(64));
        rst_n      = 1'b0;
        start      = 1'b0;
        delta_en   = 1'b0;
        scale      = 8'd1;
        bias       = '0;
        ofm_clear  = 1'b0;
        ofm_addr_m = 0;
        flg_addr_m = 0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset_state();
        test_pool_pass();
        test_relu_suppress();
        test_delta_repeat();
        test_clear_delta();
        $display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+common
common/pool_pkg.sv
design/word_packer.sv
pool/pool_window_ctrl.sv
pool/pool_lane_max.sv
pool/pool_delta.sv
pool/sparse_encoder.sv
design/pool_top.sv
bench/pool_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the pooling testbench with Verilator, run it, and decide pass or fail from the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f project.f --top-module pool_tb -o pool_sim \
    && ./obj_dir/pool_sim | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }

grep -q "ALL CHECKS PASSED" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }
